//--- Makefile
SIM      = verilator
TOP      = rate_ctrl_tb
FILELIST = sources.f
FLAGS    = --binary --timing --timescale 1ns/1ps
LINT     = --lint-only -Wall --timing --timescale 1ns/1ps
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- logic/host_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module host_reg_decode #(
    parameter int START_KP = 2
) (
    input  wire                                  wb_clk_i,
    input  wire                                  reset_i,
    input  wire  rate_ctrl_pkg::host_req_t       wb_host_i,
    output logic                                 wb_ack_o,
    output logic [rate_ctrl_pkg::DATA_W-1:0]     wb_dat_o,
    output logic [7:0]                           beam_sel_o,
    input  wire  [rate_ctrl_pkg::DATA_W-1:0]     count_i,
    input  wire  [rate_ctrl_pkg::THRESH_W-1:0]   thresh_i
);
    import rate_ctrl_pkg::*;

    localparam logic [DATA_W-1:0] KP_WORD = DATA_W'(START_KP); // Loop gain read-back

    host_state_e       state_q;
    logic [DATA_W-1:0] resp_q;   // Read response, valid with the ack

    assign beam_sel_o = wb_host_i.adr[7:0]; // Beam number for the storage lookup
    assign wb_ack_o   = (state_q == HOST_ACK);
    assign wb_dat_o   = resp_q;

    ////////////////////////////////////////////////////////////
    // Host-port FSM
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= HOST_IDLE;
        end else begin
            case (state_q)
                HOST_IDLE: begin
                    if (wb_host_i.cyc && wb_host_i.stb) begin
                        state_q <= wb_host_i.we ? HOST_WRITE : HOST_READ;
                    end
                end
                HOST_WRITE: state_q <= HOST_ACK; // Writes are accepted but dropped
                HOST_READ:  state_q <= HOST_ACK;
                default:    state_q <= HOST_IDLE; // Ack lasts one cycle
            endcase
        end
    end

    // Response mux, count takes priority over threshold
    always_ff @(posedge wb_clk_i) begin
        if (state_q == HOST_READ) begin
            if (wb_host_i.adr[HOST_SEL_COUNT]) begin
                resp_q <= count_i;
            end else if (wb_host_i.adr[HOST_SEL_THRESH]) begin
                resp_q <= {{(DATA_W-THRESH_W){1'b0}}, thresh_i};
            end else begin
                resp_q <= KP_WORD;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/loop_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module loop_sequencer #(
    parameter int NBEAMS      = 2,
    parameter int BOOT_CYCLES = 31
) (
    input  wire                                  wb_clk_i,
    input  wire                                  reset_i,
    output logic                                 cmd_valid_o,
    output rate_ctrl_pkg::bus_cmd_t              cmd_o,
    input  wire                                  done_i,
    input  wire  [rate_ctrl_pkg::DATA_W-1:0]     rdata_i,
    output logic                                 count_we_o,
    output logic                                 calc_o,
    output logic                                 commit_o,
    output logic [7:0]                           beam_o,
    input  wire  [rate_ctrl_pkg::THRESH_W-1:0]   pending_i
);
    import rate_ctrl_pkg::*;

    localparam int BOOT_W = (BOOT_CYCLES > 0) ? $clog2(BOOT_CYCLES + 1) : 1;

    loop_state_e       state_q;
    logic              busy_q;      // Command handed to the bus master
    logic [7:0]        beam_q;      // Beam being worked on
    logic [BOOT_W-1:0] boot_q;      // Boot delay countdown
    logic              last_beam;
    logic              ack_seen;    // Outstanding command finished
    logic [ADDR_W-1:0] beam_adr;

    assign last_beam = (beam_q == 8'(NBEAMS - 1));
    assign ack_seen  = busy_q && done_i;
    assign beam_adr  = ADDR_W'(beam_q);
    assign beam_o    = beam_q;

    // Strobes into the threshold storage
    assign count_we_o = (state_q == LOOP_READ_COUNTS) && ack_seen; // rdata_i holds the count
    assign calc_o     = (state_q == LOOP_CALC);                    // One beam per cycle
    assign commit_o   = (state_q == LOOP_UPDATE) && ack_seen;

    ////////////////////////////////////////////////////////////
    // Command builder, stable while the command is outstanding
    always_comb begin
        cmd_o = '{we: 1'b1, adr: ADR_CONTROL, dat: CMD_START};
        case (state_q)
            LOOP_POLL: begin
                cmd_o = '{we: 1'b0, adr: ADR_CONTROL, dat: '0}; // Status word
            end
            LOOP_READ_COUNTS: begin
                cmd_o = '{we: 1'b0, adr: ADR_BEAM + beam_adr, dat: '0};
            end
            LOOP_WRITE_THRESH: begin
                cmd_o = '{we: 1'b1, adr: ADR_BEAM + beam_adr,
                          dat: {{(DATA_W-THRESH_W){1'b0}}, pending_i}};
            end
            LOOP_ENABLE_THRESH: begin
                cmd_o = '{we: 1'b1, adr: ADR_ENABLE + beam_adr, dat: DATA_W'(1)};
            end
            LOOP_UPDATE: begin
                cmd_o = '{we: 1'b1, adr: ADR_CONTROL, dat: CMD_UPDATE};
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Loop FSM
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q     <= LOOP_BOOT;
            busy_q      <= 1'b0;
            cmd_valid_o <= 1'b0;
            beam_q      <= '0;
            boot_q      <= BOOT_W'(BOOT_CYCLES);
        end else begin
            cmd_valid_o <= 1'b0;
            case (state_q)
                LOOP_BOOT: begin
                    if (boot_q != '0) boot_q <= boot_q - 1'b1;
                    else state_q <= LOOP_WRITE_THRESH; // Push starting thresholds first
                end
                LOOP_CALC: begin
                    if (last_beam) begin
                        beam_q  <= '0;
                        state_q <= LOOP_WRITE_THRESH;
                    end else begin
                        beam_q <= beam_q + 1'b1;
                    end
                end
                default: begin
                    if (!busy_q) begin
                        cmd_valid_o <= 1'b1;            // Issue this state's transfer
                        busy_q      <= 1'b1;
                    end else if (done_i) begin
                        busy_q <= 1'b0;
                        case (state_q)
                            LOOP_START: state_q <= LOOP_POLL;
                            LOOP_POLL: begin
                                if (rdata_i[0]) begin   // Count period over
                                    beam_q  <= '0;
                                    state_q <= LOOP_READ_COUNTS;
                                end                     // Else poll again
                            end
                            LOOP_READ_COUNTS: begin
                                beam_q <= last_beam ? '0 : beam_q + 1'b1;
                                if (last_beam) state_q <= LOOP_CALC;
                            end
                            LOOP_WRITE_THRESH: begin
                                beam_q <= last_beam ? '0 : beam_q + 1'b1;
                                if (last_beam) state_q <= LOOP_ENABLE_THRESH;
                            end
                            LOOP_ENABLE_THRESH: begin
                                beam_q <= last_beam ? '0 : beam_q + 1'b1;
                                if (last_beam) state_q <= LOOP_UPDATE;
                            end
                            default: state_q <= LOOP_START; // Update done, next period
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/rate_ctrl_pkg.sv
`default_nettype none

package rate_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    localparam int ADDR_W   = 22;                     // Trigger-core and host address
    localparam int DATA_W   = 32;                     // Data word on both buses
    localparam int THRESH_W = 18;                     // One beam threshold

    localparam logic [THRESH_W-1:0] THRESH_MAX = '1;  // Upper saturation point

    ////////////////////////////////////////////////////////////
    // Trigger-core address map
    localparam logic [ADDR_W-1:0] ADR_CONTROL = 22'h000; // Start / update / status word
    localparam logic [ADDR_W-1:0] ADR_BEAM    = 22'h100; // Count read, threshold write
    localparam logic [ADDR_W-1:0] ADR_ENABLE  = 22'h200; // Per-beam threshold enable

    localparam logic [DATA_W-1:0] CMD_START  = 32'd1; // Begin a count period
    localparam logic [DATA_W-1:0] CMD_UPDATE = 32'd2; // Apply all thresholds at once

    // Host address bits, beam number in adr[7:0]
    localparam int HOST_SEL_COUNT  = 8;
    localparam int HOST_SEL_THRESH = 9;

    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_WRITE,
        HOST_READ,
        HOST_ACK
    } host_state_e;

    typedef enum logic [2:0] {
        LOOP_BOOT,
        LOOP_START,
        LOOP_POLL,
        LOOP_READ_COUNTS,
        LOOP_CALC,
        LOOP_WRITE_THRESH,
        LOOP_ENABLE_THRESH,
        LOOP_UPDATE
    } loop_state_e;

    // One transaction for the bus master
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } bus_cmd_t;

    // Outgoing trigger-core bus
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } bus_req_t;

    // Incoming host bus, same shape as the trigger side
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } host_req_t;

endpackage

`default_nettype wire

//--- logic/rate_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module rate_ctrl_top #(
    parameter int NBEAMS       = 2,
    parameter int START_THRESH = 3500,
    parameter int TARGET_COUNT = 101,
    parameter int START_KP     = 2,
    parameter int COUNT_MARGIN = 10,
    parameter int BOOT_CYCLES  = 31
) (
    input  wire                                wb_clk_i,
    input  wire                                reset_i,
    input  wire  rate_ctrl_pkg::host_req_t     wb_host_i,
    output logic                               wb_ack_o,
    output logic [rate_ctrl_pkg::DATA_W-1:0]   wb_dat_o,
    output rate_ctrl_pkg::bus_req_t            wb_trig_o,
    input  wire                                wb_trig_ack_i,
    input  wire  [rate_ctrl_pkg::DATA_W-1:0]   wb_trig_dat_i
);
    import rate_ctrl_pkg::*;

    logic                cmd_valid;
    bus_cmd_t            cmd;
    logic                done;
    logic [DATA_W-1:0]   rdata;      // Status and count words from the core
    logic                count_we;
    logic                calc;
    logic                commit;
    logic [7:0]          beam;
    logic [THRESH_W-1:0] pending;
    logic [7:0]          host_beam;  // Host read-back lookup
    logic [DATA_W-1:0]   rd_count;
    logic [THRESH_W-1:0] rd_thresh;

    ////////////////////////////////////////////////////////////
    // Host side
    host_reg_decode #(.START_KP(START_KP)) u_decode (
        .wb_clk_i, .reset_i, .wb_host_i, .wb_ack_o, .wb_dat_o,
        .beam_sel_o(host_beam), .count_i(rd_count), .thresh_i(rd_thresh)
    );

    // Control loop
    loop_sequencer #(.NBEAMS(NBEAMS), .BOOT_CYCLES(BOOT_CYCLES)) u_seq (
        .wb_clk_i, .reset_i, .cmd_valid_o(cmd_valid), .cmd_o(cmd),
        .done_i(done), .rdata_i(rdata), .count_we_o(count_we), .calc_o(calc),
        .commit_o(commit), .beam_o(beam), .pending_i(pending)
    );

    trigger_bus_master u_master (
        .wb_clk_i, .reset_i, .cmd_valid_i(cmd_valid), .cmd_i(cmd),
        .wb_trig_o, .wb_trig_ack_i, .wb_trig_dat_i, .done_o(done), .rdata_o(rdata)
    );

    threshold_calc #(
        .NBEAMS(NBEAMS), .START_THRESH(START_THRESH), .TARGET_COUNT(TARGET_COUNT),
        .START_KP(START_KP), .COUNT_MARGIN(COUNT_MARGIN)
    ) u_calc (
        .wb_clk_i, .reset_i, .count_we_i(count_we), .calc_i(calc), .commit_i(commit),
        .beam_i(beam), .count_i(rdata), .pending_o(pending),
        .rd_beam_i(host_beam), .rd_count_o(rd_count), .rd_thresh_o(rd_thresh)
    );

endmodule

`default_nettype wire

//--- logic/threshold_calc.sv
`timescale 1ns/1ps
`default_nettype none

module threshold_calc #(
    parameter int NBEAMS       = 2,
    parameter int START_THRESH = 3500,
    parameter int TARGET_COUNT = 101,
    parameter int START_KP     = 2,
    parameter int COUNT_MARGIN = 10
) (
    input  wire                                  wb_clk_i,
    input  wire                                  reset_i,
    input  wire                                  count_we_i,
    input  wire                                  calc_i,
    input  wire                                  commit_i,
    input  wire  [7:0]                           beam_i,
    input  wire  [rate_ctrl_pkg::DATA_W-1:0]     count_i,
    output logic [rate_ctrl_pkg::THRESH_W-1:0]   pending_o,
    input  wire  [7:0]                           rd_beam_i,
    output logic [rate_ctrl_pkg::DATA_W-1:0]     rd_count_o,
    output logic [rate_ctrl_pkg::THRESH_W-1:0]   rd_thresh_o
);
    import rate_ctrl_pkg::*;

    localparam int IDX_W = (NBEAMS > 1) ? $clog2(NBEAMS) : 1;
    localparam logic [THRESH_W-1:0] KP       = THRESH_W'(START_KP);
    localparam logic [THRESH_W-1:0] INIT_THR = THRESH_W'(START_THRESH);
    localparam logic [DATA_W-1:0]   HI_LIMIT = DATA_W'(TARGET_COUNT + COUNT_MARGIN);
    localparam logic [DATA_W-1:0]   LO_LIMIT =                  // Clamped at zero
        (TARGET_COUNT > COUNT_MARGIN) ? DATA_W'(TARGET_COUNT - COUNT_MARGIN) : '0;

    logic [NBEAMS-1:0][DATA_W-1:0]   count_q;    // Last measured rates
    logic [NBEAMS-1:0][THRESH_W-1:0] pending_q;  // Recalculated, not yet applied
    logic [NBEAMS-1:0][THRESH_W-1:0] thresh_q;   // Applied in the trigger core
    logic [IDX_W-1:0]                idx;
    logic [IDX_W-1:0]                rd_idx;
    logic                            beam_ok;
    logic                            rd_ok;
    logic [THRESH_W:0]               sum;        // Extra bit catches overflow
    logic [THRESH_W-1:0]             next_thr;

    assign idx     = beam_i[IDX_W-1:0];
    assign rd_idx  = rd_beam_i[IDX_W-1:0];
    assign beam_ok = (beam_i < 8'(NBEAMS));
    assign rd_ok   = (rd_beam_i < 8'(NBEAMS));

    assign pending_o   = beam_ok ? pending_q[idx] : '0;
    assign rd_count_o  = rd_ok ? count_q[rd_idx] : '0;  // Unknown beams read as zero
    assign rd_thresh_o = rd_ok ? thresh_q[rd_idx] : '0;

    ////////////////////////////////////////////////////////////
    // Margin rule, step by KP with saturation at both ends
    always_comb begin
        sum = {1'b0, thresh_q[idx]} + {1'b0, KP};
        if (count_q[idx] > HI_LIMIT) begin
            next_thr = sum[THRESH_W] ? THRESH_MAX : sum[THRESH_W-1:0];  // Too many triggers
        end else if (count_q[idx] < LO_LIMIT) begin
            next_thr = (thresh_q[idx] < KP) ? '0 : thresh_q[idx] - KP; // Too few
        end else begin
            next_thr = thresh_q[idx];                                  // Inside the band
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            count_q   <= '0;
            pending_q <= {NBEAMS{INIT_THR}};
            thresh_q  <= {NBEAMS{INIT_THR}};
        end else begin
            if (count_we_i && beam_ok) count_q[idx] <= count_i;
            if (calc_i && beam_ok) pending_q[idx] <= next_thr; // Ready next cycle
            if (commit_i) thresh_q <= pending_q;               // All beams at once
        end
    end

endmodule

`default_nettype wire

//--- logic/trigger_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_bus_master (
    input  wire                                wb_clk_i,
    input  wire                                reset_i,
    input  wire                                cmd_valid_i,
    input  wire  rate_ctrl_pkg::bus_cmd_t      cmd_i,
    output rate_ctrl_pkg::bus_req_t            wb_trig_o,
    input  wire                                wb_trig_ack_i,
    input  wire  [rate_ctrl_pkg::DATA_W-1:0]   wb_trig_dat_i,
    output logic                               done_o,
    output logic [rate_ctrl_pkg::DATA_W-1:0]   rdata_o
);
    import rate_ctrl_pkg::*;

    logic              cyc_q;   // Cycle in flight
    logic              we_q;
    logic [ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0] dat_q;
    logic              ack_hit;

    assign ack_hit = cyc_q && wb_trig_ack_i; // Core accepted the transfer

    // cyc and stb move together, all byte lanes on
    always_comb begin
        wb_trig_o.cyc = cyc_q;
        wb_trig_o.stb = cyc_q;
        wb_trig_o.we  = we_q;
        wb_trig_o.sel = {4{cyc_q}};
        wb_trig_o.adr = adr_q;
        wb_trig_o.dat = dat_q;
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            cyc_q  <= 1'b0;
            we_q   <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= ack_hit;             // One-cycle completion pulse
            if (ack_hit) begin
                cyc_q <= 1'b0;             // Release the bus
                we_q  <= 1'b0;
            end else if (cmd_valid_i && !cyc_q) begin
                cyc_q <= 1'b1;
                we_q  <= cmd_i.we;
            end
        end
    end

    // Address, data and read capture
    always_ff @(posedge wb_clk_i) begin
        if (cmd_valid_i && !cyc_q) begin
            adr_q <= cmd_i.adr;
            dat_q <= cmd_i.dat;
        end
        if (ack_hit) rdata_o <= wb_trig_dat_i; // Valid with done_o
    end

endmodule

`default_nettype wire

//--- sources.f
logic/rate_ctrl_pkg.sv
logic/host_reg_decode.sv
logic/trigger_bus_master.sv
logic/loop_sequencer.sv
logic/threshold_calc.sv
logic/rate_ctrl_top.sv
tb/trigger_core_model.sv
tb/rate_ctrl_tb.sv

//--- tb/rate_ctrl_stimulus.txt
// Columns (hex): count beam 0, count beam 1, expected threshold beam 0, beam 1
// One line per loop period; start threshold 5, KP 2, hold band 91 to 111
96 32 7 3
65 14 7 1
6f 5a 7 0
70 0 9 0
5b c8 9 2
5a 6e 7 2
12c 5b 9 2
a 70 7 4

//--- tb/rate_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rate_ctrl_tb;
    import rate_ctrl_pkg::*;

    localparam int NBEAMS       = 2;
    localparam int START_THRESH = 5;     // Low start so beam 1 reaches zero
    localparam int START_KP     = 2;
    localparam int NLOOPS       = 8;
    localparam int COLS         = 2 * NBEAMS;  // Counts then expected thresholds
    localparam int HOST_TIMEOUT = 10;
    localparam int LOOP_TIMEOUT = 1000;  // Cycles for one loop period
    localparam int MAX_POLLS    = 64;
    localparam logic [ADDR_W-1:0] HOST_CNT = ADDR_W'(1) << HOST_SEL_COUNT;
    localparam logic [ADDR_W-1:0] HOST_THR = ADDR_W'(1) << HOST_SEL_THRESH;

    logic                          wb_clk_i;
    logic                          reset_i;
    host_req_t                     host;
    logic                          wb_ack_o;
    logic [DATA_W-1:0]             wb_dat_o;
    bus_req_t                      trig;
    logic                          trig_ack;
    logic [DATA_W-1:0]             trig_dat;
    logic [NBEAMS-1:0][DATA_W-1:0] counts;    // Rates the core reports this period
    logic                          hold;      // Parks the loop in the poll state
    logic                          xfer_valid;
    bus_cmd_t                      xfer;

    logic [DATA_W-1:0] stim [NLOOPS*COLS];
    logic [DATA_W-1:0] exp_cnt [NBEAMS];
    logic [DATA_W-1:0] exp_thr [NBEAMS];
    bus_cmd_t          log_q [$];             // Every transfer seen by the core
    int                ptr      = 0;
    int                updates  = 0;
    int                checks   = 0;
    int                errors   = 0;
    int                timeouts = 0;

    rate_ctrl_top #(
        .NBEAMS(NBEAMS), .START_THRESH(START_THRESH), .TARGET_COUNT(101),
        .START_KP(START_KP), .COUNT_MARGIN(10), .BOOT_CYCLES(31)
    ) dut (
        .wb_clk_i, .reset_i, .wb_host_i(host), .wb_ack_o, .wb_dat_o,
        .wb_trig_o(trig), .wb_trig_ack_i(trig_ack), .wb_trig_dat_i(trig_dat)
    );

    trigger_core_model #(.NBEAMS(NBEAMS), .SEED(32'h5b66)) u_core (
        .wb_clk_i, .reset_i, .bus_i(trig), .ack_o(trig_ack), .dat_o(trig_dat),
        .counts_i(counts), .hold_i(hold), .xfer_valid_o(xfer_valid), .xfer_o(xfer)
    );

    always #4 wb_clk_i = ~wb_clk_i;  // 8 ns period

    always @(posedge wb_clk_i) begin
        if (xfer_valid) begin
            log_q.push_back(xfer);
            if (xfer.we && xfer.adr == ADR_CONTROL && xfer.dat == CMD_UPDATE) updates++;
        end
    end

    // All byte lanes selected while a cycle is open
    always @(negedge wb_clk_i) begin
        if (trig.cyc) check(32'(trig.sel), 32'hf, "trigger bus byte select");
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    task automatic check(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                         input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic bus_cmd_t next_xfer();
        bus_cmd_t e;
        e = '0;
        if (ptr < log_q.size()) begin
            e = log_q[ptr];
        end else begin
            errors++;
            $display("The trigger core saw fewer transfers than the loop sequence needs");
        end
        ptr++;
        return e;
    endfunction

    task automatic expect_xfer(input logic we, input logic [ADDR_W-1:0] adr,
                               input logic [DATA_W-1:0] dat, input string what);
        bus_cmd_t e;
        e = next_xfer();
        check(32'(e.we), 32'(we), {what, " direction"});
        check(32'(e.adr), 32'(adr), {what, " address"});
        check(e.dat, dat, {what, " data"});
    endtask

    // Ack must come 2 cycles after the strobe and last one cycle
    task automatic host_access(input logic we, input logic [ADDR_W-1:0] adr,
                               input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
        int waited;
        waited = 0;
        @(negedge wb_clk_i);
        host = '{cyc: 1'b1, stb: 1'b1, we: we, sel: 4'hf, adr: adr, dat: wdat};
        while (!wb_ack_o && waited < HOST_TIMEOUT) begin
            @(negedge wb_clk_i);
            waited++;
        end
        if (!wb_ack_o) begin
            timeouts++;
            $display("Host access to address %h was never acknowledged", adr);
        end
        check(32'(waited), 32'd2, "host ack latency");
        rdat = wb_dat_o;
        host = '0;
        @(negedge wb_clk_i);
        check(32'(wb_ack_o), 32'd0, "host ack width");
    endtask

    task automatic wait_updates(input int target);
        int waited;
        waited = 0;
        while (updates < target && waited < LOOP_TIMEOUT) begin
            @(negedge wb_clk_i);
            waited++;
        end
        if (updates < target) begin
            timeouts++;
            $display("Timed out waiting for update write %0d from the control loop", target);
        end
    endtask

    task automatic set_counts(input int n);
        int b;
        for (b = 0; b < NBEAMS; b++) counts[b] = stim[n*COLS + b];
    endtask

    task automatic readback();
        logic [DATA_W-1:0] rd;
        int                b;
        for (b = 0; b < NBEAMS; b++) begin  // Counts first as they change soonest
            host_access(1'b0, HOST_CNT | ADDR_W'(b), '0, rd);
            check(rd, exp_cnt[b], $sformatf("count read-back beam %0d", b));
        end
        for (b = 0; b < NBEAMS; b++) begin
            host_access(1'b0, HOST_THR | ADDR_W'(b), '0, rd);
            check(rd, exp_thr[b], $sformatf("threshold read-back beam %0d", b));
        end
    endtask

    // Start, status polls, count reads
    task automatic check_measure();
        bus_cmd_t e;
        int       polls;
        int       b;
        expect_xfer(1'b1, ADR_CONTROL, CMD_START, "start write");
        polls = 0;
        e = next_xfer();
        while (!e.we && e.adr == ADR_CONTROL && !e.dat[0] && polls < MAX_POLLS) begin
            e = next_xfer();
            polls++;
        end
        check(32'(e.we), 32'd0, "status read direction");
        check(32'(e.adr), 32'(ADR_CONTROL), "status read address");
        for (b = 0; b < NBEAMS; b++) begin
            e = next_xfer();
            check(32'(e.we), 32'd0, $sformatf("count read beam %0d direction", b));
            check(32'(e.adr), 32'(ADR_BEAM + ADDR_W'(b)),
                  $sformatf("count read beam %0d address", b));
        end
    endtask

    // Threshold writes, enables, update
    task automatic check_apply();
        int b;
        for (b = 0; b < NBEAMS; b++) begin
            expect_xfer(1'b1, ADR_BEAM + ADDR_W'(b), exp_thr[b],
                        $sformatf("threshold write beam %0d", b));
        end
        for (b = 0; b < NBEAMS; b++) begin
            expect_xfer(1'b1, ADR_ENABLE + ADDR_W'(b), DATA_W'(1),
                        $sformatf("enable write beam %0d", b));
        end
        expect_xfer(1'b1, ADR_CONTROL, CMD_UPDATE, "update write");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int                n;
        int                b;
        logic [DATA_W-1:0] rd;
        wb_clk_i = 1'b0;
        reset_i  = 1'b1;
        host     = '0;
        hold     = 1'b0;
        $readmemh("tb/rate_ctrl_stimulus.txt", stim);
        set_counts(0);
        for (b = 0; b < NBEAMS; b++) begin
            exp_cnt[b] = '0;
            exp_thr[b] = DATA_W'(START_THRESH);
        end
        repeat (2) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        reset_i = 1'b0;

        wait_updates(1);                 // Boot writes end with the first update
        if (timeouts == 0) begin
            readback();
            check_apply();
        end
        for (n = 0; n < NLOOPS && timeouts == 0; n++) begin
            wait_updates(n + 2);
            if (timeouts == 0) begin
                if (n == NLOOPS - 1) hold = 1'b1;  // Stop after the last period
                else set_counts(n + 1);
                for (b = 0; b < NBEAMS; b++) begin
                    exp_cnt[b] = stim[n*COLS + b];
                    exp_thr[b] = stim[n*COLS + NBEAMS + b];
                end
                readback();
                check_measure();
                check_apply();
            end
        end

        // Loop is parked now, so read-back values stay put
        if (timeouts == 0) begin
            host_access(1'b1, HOST_THR, 32'h0003_ffff, rd);
            host_access(1'b1, HOST_CNT | ADDR_W'(1), 32'hdead_beef, rd);
            host_access(1'b0, '0, '0, rd);
            check(rd, DATA_W'(START_KP), "KP read-back");
            readback();
        end

        $display("Done: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/trigger_core_model.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_core_model #(
    parameter int          NBEAMS = 2,
    parameter logic [31:0] SEED   = 32'h1
) (
    input  wire                                          wb_clk_i,
    input  wire                                          reset_i,
    input  wire  rate_ctrl_pkg::bus_req_t                bus_i,
    output logic                                         ack_o,
    output logic [rate_ctrl_pkg::DATA_W-1:0]             dat_o,
    input  wire  [NBEAMS-1:0][rate_ctrl_pkg::DATA_W-1:0] counts_i,
    input  wire                                          hold_i,
    output logic                                         xfer_valid_o,
    output rate_ctrl_pkg::bus_cmd_t                      xfer_o
);
    import rate_ctrl_pkg::*;

    int unsigned delay;       // Ack wait in cycles
    int unsigned polls_left;  // Status reads still answered with 0
    int          b;

    ////////////////////////////////////////////////////////////
    // Bus target answering on the falling edge
    initial begin
        void'($urandom(SEED));
        ack_o        = 1'b0;
        dat_o        = '0;
        xfer_valid_o = 1'b0;
        xfer_o       = '0;
        polls_left   = 0;
        forever begin
            @(negedge wb_clk_i);
            ack_o        = 1'b0;  // Ack lasts one cycle
            xfer_valid_o = 1'b0;
            if (!reset_i && bus_i.cyc && bus_i.stb) begin
                delay = $urandom_range(4, 0);
                repeat (delay) @(negedge wb_clk_i);
                dat_o = '0;
                if (bus_i.we) begin
                    if (bus_i.adr == ADR_CONTROL && bus_i.dat == CMD_START) begin
                        polls_left = $urandom_range(3, 0);  // New count period
                    end
                end else if (bus_i.adr == ADR_CONTROL) begin
                    if (polls_left != 0) polls_left--;
                    else dat_o = DATA_W'(!hold_i);          // Bit 0 marks the period done
                end else begin
                    for (b = 0; b < NBEAMS; b++) begin
                        if (bus_i.adr == ADR_BEAM + ADDR_W'(b)) dat_o = counts_i[b];
                    end
                end
                ack_o        = 1'b1;
                xfer_valid_o = 1'b1;
                // Reads are logged with the data handed back
                xfer_o = '{we: bus_i.we, adr: bus_i.adr,
                           dat: bus_i.we ? bus_i.dat : dat_o};
            end
        end
    end

endmodule

`default_nettype wire
